/* ray_intersect.f */
+incdir+tb
logic/ray_pkg.sv
logic/iter_counter.sv
logic/isqrt_unit.sv
logic/div_unit.sv
logic/quadric_coeffs.sv
logic/root_sequencer.sv
logic/ray_intersect.sv
tb/tb_ray_intersect.sv

/* Bender.yml */
package:
  name: ray_intersect

sources:
  - logic/ray_pkg.sv
  - logic/iter_counter.sv
  - logic/isqrt_unit.sv
  - logic/div_unit.sv
  - logic/quadric_coeffs.sv
  - logic/root_sequencer.sv
  - logic/ray_intersect.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_ray_intersect.sv

/* tb/ray_ref.svh */
`ifndef RAY_REF_SVH
`define RAY_REF_SVH

function automatic longint widen(coord_t v);
  return v;
endfunction

// nearest non-negative hit of one pair, every product kept exact before flooring
function automatic hit_t ray_ref(ray_t r, obj_t o);
  longint ocx, ocy, ocz, dx, dy, dz, kx, ky, kz;
  longint dk, ock, rad, a, h, c, disc, num, q;
  longint unsigned root, cand;
  hit_t res;
  ocx = widen(r.origin.x) - widen(o.center.x);
  ocy = widen(r.origin.y) - widen(o.center.y);
  ocz = widen(r.origin.z) - widen(o.center.z);
  dx  = widen(r.dir.x);
  dy  = widen(r.dir.y);
  dz  = widen(r.dir.z);
  kx  = widen(o.axis.x);
  ky  = widen(o.axis.y);
  kz  = widen(o.axis.z);
  dk  = dx * kx + dy * ky + dz * kz;
  ock = ocx * kx + ocy * ky + ocz * kz;
  rad = o.is_cylinder ? (49 * 65536) / 100 : 65536;  // 0.49 or 1.0
  if (!o.is_cylinder) begin
    dk  = 0;
    ock = 0;
  end
  // Q16.16 terms lifted to Q32.32 so the axis products subtract exactly
  a    = ((dx * dx + dy * dy + dz * dz) * 65536 - dk * dk) >>> 16;
  h    = ((ocx * dx + ocy * dy + ocz * dz) * 65536 - ock * dk) >>> 16;
  c    = ((ocx * ocx + ocy * ocy + ocz * ocz - rad) * 65536 - ock * ock) >>> 16;
  disc = h * h - a * c;
  res  = '0;
  if (disc < 0 || a <= 0) return res;
  root = 0;
  for (int b = 31; b >= 0; b--) begin
    cand = root | (64'd1 << b);
    if (cand * cand <= $unsigned(disc)) root = cand;
  end
  num = (-h - longint'(root)) * 256;
  q   = num / a;
  if (num % a != 0 && num < 0) q--;  // division truncates, the rule floors
  if (q >= 0) begin
    res.hit = 1'b1;
    res.t   = coord_t'(q);
  end
  return res;
endfunction

`endif

/* tb/tb_ray_intersect.sv */
`timescale 1ns/100ps

module tb_ray_intersect import ray_pkg::*; ();

  localparam int unsigned SEED  = 32'ha4ef9edb;
  localparam int RANDOM_ITEMS   = 200;
  localparam int TOTAL_ITEMS    = RANDOM_ITEMS + 14;  // 6 directed and 8 sent into a stall
  localparam int TIMEOUT_CYCLES = 90 * TOTAL_ITEMS + 200;
  localparam coord_t ONE        = 16'sh0100;

  logic aclk = 1'b0;
  logic reset;
  ray_t ray_axis_tdata;
  obj_t obj_axis_tdata;
  hit_t t_axis_tdata;
  logic ray_axis_tvalid, ray_axis_tready, obj_axis_tvalid, obj_axis_tready;
  logic t_axis_tvalid, t_axis_tready;
  logic gaps_on, ready_random, stall_hold;
  logic held = 1'b0;
  hit_t held_data;
  hit_t exp_res;
  hit_t expected_q[$];
  int   value_errors = 0, other_errors = 0, sent = 0, received = 0, cycles = 0;

  `include "ray_ref.svh"

  ray_intersect UUT (.*);

  always #4 aclk = ~aclk;

  function automatic ray_t make_ray(coord_t ox, coord_t oy, coord_t oz,
                                    coord_t dx, coord_t dy, coord_t dz);
    return {ox, oy, oz, dx, dy, dz};
  endfunction

  function automatic obj_t make_obj(coord_t cx, coord_t cy, coord_t cz,
                                    coord_t ky, coord_t kz, logic cyl);
    return {cx, cy, cz, 16'sd0, ky, kz, cyl};  // axes stay in the y/z plane
  endfunction

  function automatic coord_t rand_coord(int span);
    return coord_t'(int'($urandom_range(0, 2 * span - 1)) - span);
  endfunction

  // |dir.x| of at least 0.5 keeps a >= 0.25 for either axis
  task automatic random_pair(output ray_t r, output obj_t o);
    coord_t dx;
    logic   axis_z;
    dx     = coord_t'($urandom_range(ONE / 2, ONE));
    axis_z = $urandom_range(0, 1);
    if ($urandom_range(0, 1)) dx = -dx;
    r = make_ray(rand_coord(2 * ONE), rand_coord(2 * ONE), rand_coord(2 * ONE),
                 dx, rand_coord(ONE), rand_coord(ONE));
    o = make_obj(rand_coord(2 * ONE), rand_coord(2 * ONE), rand_coord(2 * ONE),
                 axis_z ? 16'sd0 : ONE, axis_z ? ONE : 16'sd0, $urandom_range(0, 1));
  endtask

  task automatic send_pair(input ray_t r, input obj_t o, input hit_t want);
    int gap_r, gap_o;
    gap_r = gaps_on ? $urandom_range(0, 3) : 0;
    gap_o = gaps_on ? $urandom_range(0, 3) : 0;
    ray_axis_tvalid = 1'b0;
    obj_axis_tvalid = 1'b0;
    ray_axis_tdata  = r;
    obj_axis_tdata  = o;
    // either stream may wait alone for the other
    for (int i = 0; !(ray_axis_tvalid && obj_axis_tvalid); i++) begin
      if (i >= gap_r) ray_axis_tvalid = 1'b1;
      if (i >= gap_o) obj_axis_tvalid = 1'b1;
      if (!(ray_axis_tvalid && obj_axis_tvalid)) @(negedge aclk);
    end
    expected_q.push_back(want);
    sent++;
    do @(posedge aclk); while (!ray_axis_tready);
    @(negedge aclk);
  endtask

  task automatic finish_run();
    $display("%0d wrong values, %0d other errors, %0d of %0d results checked",
             value_errors, other_errors, received, TOTAL_ITEMS);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  always @(negedge aclk) begin
    t_axis_tready = !stall_hold && (!ready_random || $urandom_range(0, 3) != 0);
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: %0d cycles passed with %0d results still missing", cycles,
               sent - received);
      other_errors++;
      finish_run();
    end
  end

  always @(posedge aclk) begin
    if (ray_axis_tready !== obj_axis_tready) begin
      $display("CHECK FAILED at %0t: obj_axis_tready expected %b, got %b",
               $time, ray_axis_tready, obj_axis_tready);
      value_errors++;
    end
    if (ray_axis_tready && !(ray_axis_tvalid && obj_axis_tvalid)) begin
      $display("CHECK FAILED at %0t: ray_axis_tready expected 0, got %b",
               $time, ray_axis_tready);
      value_errors++;
    end
    if (held && t_axis_tvalid !== 1'b1) begin
      $display("CHECK FAILED at %0t: t_axis_tvalid expected 1, got %b", $time, t_axis_tvalid);
      value_errors++;
    end
    if (held && t_axis_tdata !== held_data) begin
      $display("CHECK FAILED at %0t: t_axis_tdata expected %h, got %h",
               $time, held_data, t_axis_tdata);
      value_errors++;
    end
    if (!reset && t_axis_tvalid && t_axis_tready) begin
      if (expected_q.size() == 0) begin
        $display("a result arrived at %0t with no pair outstanding", $time);
        other_errors++;
      end else begin
        exp_res = expected_q.pop_front();
        received++;
        if (t_axis_tdata.hit !== exp_res.hit) begin
          $display("CHECK FAILED at %0t: t_axis_tdata.hit expected %0d, got %0d",
                   $time, exp_res.hit, t_axis_tdata.hit);
          value_errors++;
        end
        if (t_axis_tdata.t !== exp_res.t) begin
          $display("CHECK FAILED at %0t: t_axis_tdata.t expected %h, got %h",
                   $time, exp_res.t, t_axis_tdata.t);
          value_errors++;
        end
      end
    end
    held      = !reset && t_axis_tvalid && !t_axis_tready;  // must not move next edge
    held_data = t_axis_tdata;
  end

  initial begin
    ray_t r;
    obj_t o;
    int unsigned seed_draw;
    seed_draw       = $urandom(SEED);
    reset           = 1'b1;
    ray_axis_tdata  = '0;
    ray_axis_tvalid = 1'b0;
    obj_axis_tdata  = '0;
    obj_axis_tvalid = 1'b0;
    t_axis_tready   = 1'b0;
    gaps_on         = 1'b0;
    ready_random    = 1'b0;
    stall_hold      = 1'b0;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    if (ray_axis_tready || obj_axis_tready || t_axis_tvalid) begin
      $display("input readies or t_axis_tvalid were high during reset");
      other_errors++;
    end
    reset = 1'b0;

    // head-on sphere 4.0 away with its surface at 3.0
    send_pair(make_ray(0, 0, -4 * ONE, 0, 0, ONE), make_obj(0, 0, 0, ONE, 0, 1'b0),
              {1'b1, 16'h0300});
    send_pair(make_ray(0, 3 * ONE, -4 * ONE, 0, 0, ONE), make_obj(0, 0, 0, ONE, 0, 1'b0), '0);
    send_pair(make_ray(0, 0, -4 * ONE, 0, 0, 0), make_obj(0, 0, 0, ONE, 0, 1'b0), '0);
    // radius 0.7 gives 4 - 0.7 floored to 0x34c
    send_pair(make_ray(-4 * ONE, 0, 0, ONE, 0, 0), make_obj(0, 0, 0, ONE, 0, 1'b1),
              {1'b1, 16'h034c});
    send_pair(make_ray(-4 * ONE, 0, 0, ONE, ONE, 0), make_obj(0, 0, 0, ONE, 0, 1'b1),
              {1'b1, 16'h034c});  // y part of dir runs along the axis
    send_pair(make_ray(0, 0, 4 * ONE, 0, 0, ONE), make_obj(0, 0, 0, ONE, 0, 1'b0), '0);

    stall_hold = 1'b1;
    fork
      repeat (8) begin
        random_pair(r, o);
        send_pair(r, o, ray_ref(r, o));
      end
      begin
        repeat (150) @(negedge aclk);
        if (ray_axis_tready || obj_axis_tready || !t_axis_tvalid) begin
          $display("input readies did not fall while t_axis_tready was held low");
          other_errors++;
        end
        stall_hold = 1'b0;
      end
    join

    gaps_on      = 1'b1;
    ready_random = 1'b1;
    repeat (RANDOM_ITEMS) begin
      random_pair(r, o);
      send_pair(r, o, ray_ref(r, o));
    end
    ray_axis_tvalid = 1'b0;
    obj_axis_tvalid = 1'b0;
    while (expected_q.size() != 0) @(posedge aclk);
    ready_random = 1'b0;  // a repeated result would be taken and flagged
    repeat (1 + SQRT_STEPS + DIV_STEPS + 8) @(negedge aclk);
    finish_run();
  end

endmodule

/* logic/ray_intersect.sv */
`timescale 1ns/100ps

module ray_intersect import ray_pkg::*; (
  input  logic aclk,
  input  logic reset,
  input  ray_t ray_axis_tdata,
  input  logic ray_axis_tvalid,
  output logic ray_axis_tready,
  input  obj_t obj_axis_tdata,
  input  logic obj_axis_tvalid,
  output logic obj_axis_tready,
  output hit_t t_axis_tdata,
  output logic t_axis_tvalid,
  input  logic t_axis_tready
);

  logic   pair_valid;
  logic   pipe_ready;
  logic   coeff_valid;
  coeff_t coeff;
  logic   coeff_ready;

  // ray and object are only taken together
  assign pair_valid      = ray_axis_tvalid && obj_axis_tvalid;
  assign ray_axis_tready = pipe_ready && pair_valid;
  assign obj_axis_tready = pipe_ready && pair_valid;

  quadric_coeffs u_coeffs (
    .aclk      (aclk),
    .reset     (reset),
    .in_valid  (pair_valid),
    .in_ray    (ray_axis_tdata),
    .in_obj    (obj_axis_tdata),
    .in_ready  (pipe_ready),
    .out_valid (coeff_valid),
    .out_coeff (coeff),
    .out_ready (coeff_ready)
  );

  root_sequencer u_solver (
    .aclk        (aclk),
    .reset       (reset),
    .coeff_valid (coeff_valid),
    .coeff       (coeff),
    .coeff_ready (coeff_ready),
    .res_valid   (t_axis_tvalid),
    .res         (t_axis_tdata),
    .res_ready   (t_axis_tready)
  );

endmodule

/* logic/root_sequencer.sv */
`timescale 1ns/100ps

module root_sequencer import ray_pkg::*; (
  input  logic   aclk,
  input  logic   reset,
  input  logic   coeff_valid,
  input  coeff_t coeff,
  output logic   coeff_ready,
  output logic   res_valid,
  output hit_t   res,
  input  logic   res_ready
);

  seq_state_t state;
  prod_t      a_q;
  prod_t      h_q;
  hit_t       res_q;
  logic       take;
  logic       early_miss;
  logic       sqrt_start;
  logic       sqrt_step;
  logic       div_start;
  logic       div_step;
  logic       cnt_load;
  logic [5:0] cnt_value;
  logic       last;
  prod_t      root;
  wide_t      dividend;
  coord_t     quotient;

  assign take       = coeff_valid && state == IDLE;
  assign early_miss = coeff.disc < 0 || coeff.a <= 0;

  // each unit retires its first step on start, the rest while counting
  assign sqrt_start = take && !early_miss;
  assign sqrt_step  = state == ROOT && !last;
  assign div_start  = state == ROOT && last;
  assign div_step   = state == DIVIDE && !last;
  assign cnt_load   = sqrt_start || div_start;
  assign cnt_value  = div_start ? 6'(DIV_STEPS) : 6'(SQRT_STEPS);

  // nearer root, scaled by 2^8 so the quotient comes out in Q8.8
  assign dividend = (-wide_t'(h_q) - wide_t'(root)) <<< 8;

  iter_counter u_cnt (
    .aclk       (aclk),
    .reset      (reset),
    .load       (cnt_load),
    .load_value (cnt_value),
    .last       (last)
  );

  isqrt_unit u_sqrt (
    .aclk     (aclk),
    .reset    (reset),
    .start    (sqrt_start),
    .step     (sqrt_step),
    .radicand (coeff.disc),
    .root     (root)
  );

  div_unit u_div (
    .aclk     (aclk),
    .reset    (reset),
    .start    (div_start),
    .step     (div_step),
    .dividend (dividend),
    .divisor  (a_q),
    .quotient (quotient)
  );

  always_ff @(posedge aclk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (coeff_valid) state <= early_miss ? EMIT : ROOT;
        ROOT:    if (last) state <= DIVIDE;
        DIVIDE:  if (last) state <= EMIT;
        EMIT:    if (res_ready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      a_q <= coeff.a;
      h_q <= coeff.h;
    end
    if (take && early_miss) begin
      res_q <= '0;
    end else if (state == DIVIDE && last) begin
      res_q.hit <= !quotient[15];
      res_q.t   <= quotient[15] ? '0 : quotient;  // behind the origin
    end
  end

  assign coeff_ready = state == IDLE;
  assign res_valid   = state == EMIT;
  assign res         = res_q;

  a_res_hold: assert property (@(posedge aclk) disable iff (reset)
    res_valid && !res_ready |=> res_valid && $stable(res));

  a_cnt_load: assert property (@(posedge aclk) disable iff (reset)
    cnt_load |=> state inside {ROOT, DIVIDE} && state != $past(state));

endmodule

/* logic/quadric_coeffs.sv */
`timescale 1ns/100ps

module quadric_coeffs import ray_pkg::*; (
  input  logic   aclk,
  input  logic   reset,
  input  logic   in_valid,
  input  ray_t   in_ray,
  input  obj_t   in_obj,
  output logic   in_ready,
  output logic   out_valid,
  output coeff_t out_coeff,
  input  logic   out_ready
);

  typedef struct packed {
    prod_t dd;
    prod_t ocd;
    prod_t ococ;
    prod_t dk;
    prod_t ock;
    logic  is_cyl;
  } s1_t;

  typedef struct packed {
    prod_t dd;
    prod_t ocd;
    prod_t ococ;
    prod_t rad;
    wide_t corr_a;
    wide_t corr_h;
    wide_t corr_c;
  } s2_t;

  typedef struct packed {
    prod_t a;
    prod_t h;
    prod_t c;
  } s3_t;

  function automatic prod_t dot3(vec3_t u, vec3_t v);
    return prod_t'(u.x) * prod_t'(v.x) + prod_t'(u.y) * prod_t'(v.y) +
           prod_t'(u.z) * prod_t'(v.z);
  endfunction

  function automatic wide_t wmul(prod_t p, prod_t q);
    return wide_t'(p) * wide_t'(q);
  endfunction

  // Q32.32 -> Q16.16, the slice floors toward minus infinity
  function automatic prod_t trunc_q16(wide_t v);
    return v[47:16];
  endfunction

  logic [COEFF_STAGES-1:0] vld;
  logic [COEFF_STAGES-1:0] adv;
  vec3_t  oc;
  s1_t    s1_d;
  s1_t    s1_q;
  s2_t    s2_d;
  s2_t    s2_q;
  s3_t    s3_d;
  s3_t    s3_q;
  coeff_t c4_d;
  coeff_t c4_q;

  // a stage may load when it is empty or its contents move on
  always_comb begin
    adv[COEFF_STAGES-1] = !vld[COEFF_STAGES-1] || out_ready;
    for (int i = COEFF_STAGES - 2; i >= 0; i--) begin
      adv[i] = !vld[i] || adv[i+1];
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      vld <= '0;
    end else begin
      if (adv[0]) vld[0] <= in_valid;
      for (int i = 1; i < COEFF_STAGES; i++) begin
        if (adv[i]) vld[i] <= vld[i-1];
      end
    end
  end

  always_comb begin
    oc.x = in_ray.origin.x - in_obj.center.x;
    oc.y = in_ray.origin.y - in_obj.center.y;
    oc.z = in_ray.origin.z - in_obj.center.z;
    s1_d.dd     = dot3(in_ray.dir, in_ray.dir);
    s1_d.ocd    = dot3(oc, in_ray.dir);
    s1_d.ococ   = dot3(oc, oc);
    s1_d.dk     = dot3(in_ray.dir, in_obj.axis);
    s1_d.ock    = dot3(oc, in_obj.axis);
    s1_d.is_cyl = in_obj.is_cylinder;
  end

  // axis projections only count for a cylinder
  always_comb begin
    s2_d.dd     = s1_q.dd;
    s2_d.ocd    = s1_q.ocd;
    s2_d.ococ   = s1_q.ococ;
    s2_d.rad    = s1_q.is_cyl ? CYL_RAD_SQ : SPHERE_RAD_SQ;
    s2_d.corr_a = s1_q.is_cyl ? wmul(s1_q.dk, s1_q.dk) : '0;
    s2_d.corr_h = s1_q.is_cyl ? wmul(s1_q.ock, s1_q.dk) : '0;
    s2_d.corr_c = s1_q.is_cyl ? wmul(s1_q.ock, s1_q.ock) : '0;
  end

  always_comb begin
    s3_d.a = trunc_q16((wide_t'(s2_q.dd) <<< 16) - s2_q.corr_a);
    s3_d.h = trunc_q16((wide_t'(s2_q.ocd) <<< 16) - s2_q.corr_h);
    s3_d.c = trunc_q16((wide_t'(s2_q.ococ - s2_q.rad) <<< 16) - s2_q.corr_c);
  end

  always_comb begin
    c4_d.a    = s3_q.a;
    c4_d.h    = s3_q.h;
    c4_d.disc = wmul(s3_q.h, s3_q.h) - wmul(s3_q.a, s3_q.c);  // exact in Q32.32
  end

  always_ff @(posedge aclk) begin
    if (adv[0] && in_valid) s1_q <= s1_d;
    if (adv[1] && vld[0]) s2_q <= s2_d;
    if (adv[2] && vld[1]) s3_q <= s3_d;
    if (adv[3] && vld[2]) c4_q <= c4_d;
  end

  assign in_ready  = adv[0];
  assign out_valid = vld[COEFF_STAGES-1];
  assign out_coeff = c4_q;

  // a stalled stage keeps its pair until the stall clears from the back
  a_s1_hold: assert property (@(posedge aclk) disable iff (reset)
    vld[0] && !adv[0] |=> vld[0] && $stable(s1_q));

  a_out_hold: assert property (@(posedge aclk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_coeff));

endmodule

/* logic/div_unit.sv */
`timescale 1ns/100ps

module div_unit import ray_pkg::*; (
  input  logic   aclk,
  input  logic   reset,
  input  logic   start,
  input  logic   step,
  input  wide_t  dividend,
  input  prod_t  divisor,    // positive here, a > 0 is checked upstream
  output coord_t quotient
);

  logic        neg_q;
  logic [31:0] rem_q;
  logic [31:0] quo_q;        // low dividend bits shift out, quotient bits shift in
  logic [63:0] mag;
  logic [31:0] cur_rem;
  logic [31:0] cur_quo;
  logic [32:0] shifted;
  logic        fits;
  logic [31:0] floored;

  always_comb begin
    mag     = dividend[63] ? 64'(-dividend) : 64'(dividend);
    cur_rem = start ? mag[63:32] : rem_q;
    cur_quo = start ? mag[31:0] : quo_q;
    shifted = {cur_rem, cur_quo[31]};
    fits    = shifted >= {1'b0, divisor};
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      neg_q <= 1'b0;
      rem_q <= '0;
      quo_q <= '0;
    end else if (start || step) begin
      if (start) neg_q <= dividend[63];
      rem_q <= fits ? 32'(shifted - {1'b0, divisor}) : shifted[31:0];
      quo_q <= {cur_quo[30:0], fits};
    end
  end

  // magnitude quotient truncates, so a negative one with a remainder steps down once more
  assign floored  = neg_q ? -(quo_q + 32'(rem_q != '0)) : quo_q;
  assign quotient = floored[15:0];

endmodule

/* logic/isqrt_unit.sv */
`timescale 1ns/100ps

module isqrt_unit import ray_pkg::*; (
  input  logic  aclk,
  input  logic  reset,
  input  logic  start,
  input  logic  step,
  input  wide_t radicand,
  output prod_t root
);

  wide_t       rad_q;     // radicand bits not yet retired, msb first
  logic [33:0] rem_q;
  logic [31:0] root_q;
  wide_t       cur_rad;
  logic [33:0] cur_rem;
  logic [31:0] cur_root;
  logic [35:0] trial_rem;
  logic [35:0] trial_sub;
  logic        fits;

  // start restarts from an empty remainder and takes the first bit pair at once
  always_comb begin
    cur_rad   = start ? radicand : rad_q;
    cur_rem   = start ? '0 : rem_q;
    cur_root  = start ? '0 : root_q;
    trial_rem = {cur_rem, cur_rad[63:62]};
    trial_sub = {2'b00, cur_root, 2'b01};  // 4*root + 1
    fits      = trial_rem >= trial_sub;
  end

  always_ff @(posedge aclk) begin
    if (start || step) rad_q <= cur_rad << 2;
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      rem_q  <= '0;
      root_q <= '0;
    end else if (start || step) begin
      rem_q  <= fits ? 34'(trial_rem - trial_sub) : trial_rem[33:0];
      root_q <= {cur_root[30:0], fits};
    end
  end

  // isqrt of a Q32.32 raw value is already Q16.16
  assign root = prod_t'(root_q);

endmodule

/* logic/iter_counter.sv */
`timescale 1ns/100ps

module iter_counter (
  input  logic       aclk,
  input  logic       reset,
  input  logic       load,
  input  logic [5:0] load_value,
  output logic       last
);

  logic [5:0] count;

  always_ff @(posedge aclk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (count != '0) begin
      count <= count - 6'd1;  // parks at zero
    end
  end

  assign last = count == 6'd1;

endmodule

/* logic/ray_pkg.sv */
package ray_pkg;

  typedef logic signed [15:0] coord_t;  // Q8.8
  typedef logic signed [31:0] prod_t;   // Q16.16
  typedef logic signed [63:0] wide_t;   // Q32.32

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  typedef struct packed {
    vec3_t origin;
    vec3_t dir;
  } ray_t;

  typedef struct packed {
    vec3_t center;
    vec3_t axis;          // unit length, only read for cylinders
    logic  is_cylinder;
  } obj_t;

  typedef struct packed {
    prod_t a;
    prod_t h;             // half of the linear term
    wide_t disc;
  } coeff_t;

  typedef struct packed {
    logic   hit;
    coord_t t;
  } hit_t;

  localparam prod_t SPHERE_RAD_SQ = 32'sh0001_0000;  // 1.0
  localparam prod_t CYL_RAD_SQ    = 32'sh0000_7d70;  // 0.49 floored to Q16.16

  localparam int COEFF_STAGES = 4;
  localparam int SQRT_STEPS   = 32;  // two radicand bits per step
  localparam int DIV_STEPS    = 32;

  typedef enum logic [1:0] {
    IDLE,
    ROOT,
    DIVIDE,
    EMIT
  } seq_state_t;

endpackage
